/* hw/icache_pkg.sv */
package icache_pkg;

    // Address layout
    localparam int ADDR_BITS   = 32;
    localparam int TAG_BITS    = 13;
    localparam int OFFSET_BITS = 3;
    localparam int ZERO_BITS   = ADDR_BITS - TAG_BITS - OFFSET_BITS;
    localparam int BLOCK_BITS  = 64;
    localparam int BLOCK_BYTES = 1 << OFFSET_BITS;

    // Storage sizes
    localparam int ICACHE_LINES  = 16;
    localparam int LINE_IDX_BITS = $clog2(ICACHE_LINES);
    localparam int MSHR_DEPTH    = 8;
    localparam int MSHR_IDX_BITS = $clog2(MSHR_DEPTH);
    localparam int MEM_TAG_BITS  = 4;

    // Any nonzero value works for the eviction LFSR
    localparam logic [LINE_IDX_BITS-1:0] LFSR_SEED = 4'b1001;

    typedef logic [TAG_BITS-1:0]     itag_t;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;
    typedef logic [BLOCK_BITS-1:0]   block_t;

    // Fetch address, seen as a plain word or as its fields
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        struct packed {
            logic [ZERO_BITS-1:0]   zeros;
            itag_t                  tag;
            logic [OFFSET_BITS-1:0] offset;
        } fields;
    } i_addr_u;

    typedef struct packed {
        logic   valid;
        itag_t  tag;
        block_t data;
    } icache_line_t;

    typedef struct packed {
        logic     valid;
        mem_tag_t mem_tag;
        itag_t    i_tag;
    } mshr_entry_t;

endpackage

/* hw/snoop_if.sv */
`timescale 1ns/1ps

// Combinational lookup path from the prefetcher into the cache and the miss queue
interface snoop_if;

    logic              snoop_valid;
    icache_pkg::itag_t snoop_tag;
    logic              found_cache;
    logic              full;
    logic              found_queue;
    logic              alloc;

    modport prefetcher (
        output snoop_valid,
        output snoop_tag,
        output alloc,
        input  found_cache,
        input  full,
        input  found_queue
    );

    modport cache (input snoop_valid, input snoop_tag, output found_cache, output full);

    modport queue (input snoop_valid, input snoop_tag, input alloc, output found_queue);

endinterface

/* hw/icache_array.sv */
`timescale 1ns/1ps

module icache_array (
    input  logic                          i_clock,
    input  logic                          i_reset,

    input  logic [1:0]                    i_read_valid,
    input  icache_pkg::i_addr_u [1:0]     i_read_addr,
    output logic [1:0]                    o_read_hit,
    output icache_pkg::block_t [1:0]      o_read_data,

    snoop_if.cache                        snoop,

    input  logic                          i_fill_valid,
    input  icache_pkg::itag_t             i_fill_tag,
    input  icache_pkg::block_t            i_fill_data
);

    icache_pkg::icache_line_t               lines [icache_pkg::ICACHE_LINES];
    logic [icache_pkg::ICACHE_LINES-1:0]      line_valid;
    logic [icache_pkg::ICACHE_LINES-1:0]      snoop_match;
    logic [1:0][icache_pkg::ICACHE_LINES-1:0] read_match;
    logic [icache_pkg::LINE_IDX_BITS-1:0]     lfsr;
    logic [icache_pkg::LINE_IDX_BITS-1:0]     free_idx;
    logic [icache_pkg::LINE_IDX_BITS-1:0]     victim_idx;
    logic                                     have_free;

    // Snoop lookup and occupancy
    always_comb begin
        for (int i = 0; i < icache_pkg::ICACHE_LINES; i++) begin
            line_valid[i]  = lines[i].valid;
            snoop_match[i] = lines[i].valid && (lines[i].tag == snoop.snoop_tag);
        end
    end

    assign snoop.found_cache = snoop.snoop_valid && (|snoop_match);
    assign snoop.full        = &line_valid;

    // Two read ports, each compared against every line
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            o_read_data[j] = '0;
            for (int i = 0; i < icache_pkg::ICACHE_LINES; i++) begin
                read_match[j][i] = i_read_valid[j] && lines[i].valid &&
                                   (lines[i].tag == i_read_addr[j].fields.tag);
                if (read_match[j][i]) begin
                    o_read_data[j] = o_read_data[j] | lines[i].data;
                end
            end
            o_read_hit[j] = |read_match[j];
        end
    end

    // Lowest invalid line wins, scanned from the top down
    always_comb begin
        have_free = 1'b0;
        free_idx  = '0;
        for (int i = icache_pkg::ICACHE_LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                have_free = 1'b1;
                free_idx  = i[icache_pkg::LINE_IDX_BITS-1:0];
            end
        end
    end

    assign victim_idx = have_free ? free_idx : lfsr;

    // Fibonacci LFSR, x^4 + x^3 + 1, free running
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            lfsr <= icache_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[icache_pkg::LINE_IDX_BITS-2:0],
                     lfsr[icache_pkg::LINE_IDX_BITS-1] ^ lfsr[icache_pkg::LINE_IDX_BITS-2]};
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < icache_pkg::ICACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (i_fill_valid) begin
            lines[victim_idx] <= '{valid: 1'b1, tag: i_fill_tag, data: i_fill_data};
        end
    end

endmodule

/* hw/miss_status_queue.sv */
`timescale 1ns/1ps

module miss_status_queue (
    input  logic                   i_clock,
    input  logic                   i_reset,

    snoop_if.queue                 snoop,

    input  icache_pkg::itag_t      i_req_tag,
    input  icache_pkg::mem_tag_t   i_current_req_tag,
    input  icache_pkg::mem_tag_t   i_mem_data_tag,

    output logic                   o_fill_valid,
    output icache_pkg::itag_t      o_fill_tag
);

    icache_pkg::mshr_entry_t              entries [icache_pkg::MSHR_DEPTH];
    logic [icache_pkg::MSHR_IDX_BITS-1:0] head;
    logic [icache_pkg::MSHR_IDX_BITS-1:0] tail;
    logic [icache_pkg::MSHR_DEPTH-1:0]    snoop_match;
    logic                                 queue_full;
    logic                                 pop;

    always_comb begin
        for (int i = 0; i < icache_pkg::MSHR_DEPTH; i++) begin
            snoop_match[i] = entries[i].valid && (entries[i].i_tag == snoop.snoop_tag);
        end
    end

    // Tail slot still in use means the ring has wrapped onto the head
    assign queue_full = entries[tail].valid;

    // A full queue also holds off new requests
    assign snoop.found_queue = snoop.snoop_valid && ((|snoop_match) || queue_full);

    // Returns arrive in request order, so only the head can match
    assign pop = (i_mem_data_tag != '0) && entries[head].valid &&
                 (entries[head].mem_tag == i_mem_data_tag);

    assign o_fill_valid = pop;
    assign o_fill_tag   = entries[head].i_tag;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < icache_pkg::MSHR_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head                <= head + 1'b1;
            end
            if (snoop.alloc) begin
                entries[tail] <= '{valid: 1'b1, mem_tag: i_current_req_tag, i_tag: i_req_tag};
                tail          <= tail + 1'b1;
            end
        end
    end

endmodule

/* hw/stream_prefetcher.sv */
`timescale 1ns/1ps

module stream_prefetcher (
    input  logic                      i_clock,
    input  logic                      i_reset,

    input  logic [1:0]                i_read_valid,
    input  icache_pkg::i_addr_u [1:0] i_read_addr,
    input  logic [1:0]                i_read_hit,

    snoop_if.prefetcher               snoop,

    input  logic                      i_mem_req_accepted,
    output logic                      o_mem_req_valid,
    output icache_pkg::i_addr_u       o_mem_req_addr
);

    logic                miss_valid;
    icache_pkg::itag_t   miss_tag;
    logic                last_miss_valid;
    icache_pkg::itag_t   last_miss_tag;
    icache_pkg::i_addr_u stream_ptr;
    icache_pkg::i_addr_u next_block;
    logic                take_miss;
    logic                take_stream;

    // Oldest missing slot, slot 0 first
    always_comb begin
        miss_valid = 1'b0;
        miss_tag   = i_read_addr[0].fields.tag;
        if (i_read_valid[0] && !i_read_hit[0]) begin
            miss_valid = 1'b1;
        end else if (i_read_valid[1] && !i_read_hit[1]) begin
            miss_valid = 1'b1;
            miss_tag   = i_read_addr[1].fields.tag;
        end
    end

    // Step one whole block past the last accepted request
    always_comb begin
        next_block.raw          = stream_ptr.raw + icache_pkg::BLOCK_BYTES;
        next_block.fields.zeros = '0;
    end

    assign take_miss   = miss_valid && (!last_miss_valid || (miss_tag != last_miss_tag));
    assign take_stream = !take_miss && !snoop.full && last_miss_valid;

    always_comb begin
        o_mem_req_addr.raw        = '0;
        o_mem_req_addr.fields.tag = take_stream ? next_block.fields.tag : miss_tag;
    end

    assign snoop.snoop_valid = take_miss || take_stream;
    assign snoop.snoop_tag   = o_mem_req_addr.fields.tag;

    // Nothing goes out for a block that is already cached or in flight
    assign o_mem_req_valid = snoop.snoop_valid && !snoop.found_cache && !snoop.found_queue;
    assign snoop.alloc     = o_mem_req_valid && i_mem_req_accepted;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            last_miss_valid <= 1'b0;
        end else if (snoop.alloc) begin
            if (take_miss) begin
                last_miss_valid <= 1'b1;
                last_miss_tag   <= miss_tag;
                stream_ptr      <= o_mem_req_addr;
            end else begin
                stream_ptr <= next_block;
            end
        end
    end

endmodule

/* hw/icache_subsystem.sv */
`timescale 1ns/1ps

module icache_subsystem (
    input  logic                      i_clock,
    input  logic                      i_reset,

    // Fetch side, slot 0 is the older
    input  logic [1:0]                i_read_valid,
    input  icache_pkg::i_addr_u [1:0] i_read_addr,
    output logic [1:0]                o_read_hit,
    output icache_pkg::block_t [1:0]  o_read_data,

    // Memory side
    input  icache_pkg::mem_tag_t      i_current_req_tag,
    input  icache_pkg::block_t        i_mem_data,
    input  icache_pkg::mem_tag_t      i_mem_data_tag,
    input  logic                      i_mem_req_accepted,
    output logic                      o_mem_req_valid,
    output icache_pkg::i_addr_u       o_mem_req_addr
);

    logic              fill_valid;
    icache_pkg::itag_t fill_tag;

    snoop_if snoop_bus ();

    icache_array cache0 (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_read_valid (i_read_valid),
        .i_read_addr  (i_read_addr),
        .o_read_hit   (o_read_hit),
        .o_read_data  (o_read_data),
        .snoop        (snoop_bus.cache),
        .i_fill_valid (fill_valid),
        .i_fill_tag   (fill_tag),
        .i_fill_data  (i_mem_data)
    );

    miss_status_queue mshr0 (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .snoop             (snoop_bus.queue),
        .i_req_tag         (o_mem_req_addr.fields.tag),
        .i_current_req_tag (i_current_req_tag),
        .i_mem_data_tag    (i_mem_data_tag),
        .o_fill_valid      (fill_valid),
        .o_fill_tag        (fill_tag)
    );

    stream_prefetcher prefetch0 (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_read_valid       (i_read_valid),
        .i_read_addr        (i_read_addr),
        .i_read_hit         (o_read_hit),
        .snoop              (snoop_bus.prefetcher),
        .i_mem_req_accepted (i_mem_req_accepted),
        .o_mem_req_valid    (o_mem_req_valid),
        .o_mem_req_addr     (o_mem_req_addr)
    );

endmodule

/* testbench/icache_subsystem_props.sv */
`timescale 1ns/1ps

module icache_subsystem_props (
    input logic                      i_clock,
    input logic                      i_reset,
    input logic [1:0]                i_read_valid,
    input icache_pkg::i_addr_u [1:0] i_read_addr,
    input logic [1:0]                o_read_hit,
    input icache_pkg::mem_tag_t      i_mem_data_tag,
    input logic                      i_mem_req_accepted,
    input logic                      o_mem_req_valid,
    input icache_pkg::i_addr_u       o_mem_req_addr
);

    // Second reset cycle onward, state is known
    req_low_in_reset: assert property (@(posedge i_clock)
        i_reset && $past(i_reset) |-> !o_mem_req_valid)
        else $error("memory request raised during reset");

    // A waiting request holds while its reads stay put and no fill lands
    req_held: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_mem_req_valid && !i_mem_req_accepted && i_mem_data_tag == '0)
        ##1 ($stable(i_read_valid) && $stable(i_read_addr))
        |-> o_mem_req_valid && $stable(o_mem_req_addr))
        else $error("memory request dropped or changed while not accepted");

    hit_needs_valid: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_read_hit & ~i_read_valid) == 2'b00)
        else $error("read hit on a slot that is not valid");

endmodule

bind icache_subsystem icache_subsystem_props props0 (
    .i_clock            (i_clock),
    .i_reset            (i_reset),
    .i_read_valid       (i_read_valid),
    .i_read_addr        (i_read_addr),
    .o_read_hit         (o_read_hit),
    .i_mem_data_tag     (i_mem_data_tag),
    .i_mem_req_accepted (i_mem_req_accepted),
    .o_mem_req_valid    (o_mem_req_valid),
    .o_mem_req_addr     (o_mem_req_addr)
);

/* testbench/icache_subsystem_tb.sv */
`timescale 1ns/1ps

module icache_subsystem_tb;

    logic                      clock;
    logic                      reset;
    logic [1:0]                read_valid;
    icache_pkg::i_addr_u [1:0] read_addr;
    logic [1:0]                read_hit;
    icache_pkg::block_t [1:0]  read_data;
    icache_pkg::mem_tag_t      current_req_tag;
    icache_pkg::block_t        mem_data;
    icache_pkg::mem_tag_t      mem_data_tag;
    logic                      mem_req_accepted;
    logic                      mem_req_valid;
    icache_pkg::i_addr_u       mem_req_addr;

    // Step fields are read valid, addr0, addr1, accept and return delay
    logic [87:0] steps [0:63];
    int          num_steps;
    int          cycle = 0;
    int          cycle_limit;
    int          fills;
    bit          filled [int];
    int          pend_tag[$];
    int          pend_due[$];
    int          mem_tags[$];
    int          next_tag;
    logic [7:0]  delay;
    bit          returning;

    // Request model state
    bit          last_miss_valid;
    int          last_miss_tag;
    int          stream_tag;
    bit          exp_req_valid;
    bit          exp_from_miss;
    int          exp_req_tag;

    icache_subsystem dut0 (
        .i_clock            (clock),
        .i_reset            (reset),
        .i_read_valid       (read_valid),
        .i_read_addr        (read_addr),
        .o_read_hit         (read_hit),
        .o_read_data        (read_data),
        .i_current_req_tag  (current_req_tag),
        .i_mem_data         (mem_data),
        .i_mem_data_tag     (mem_data_tag),
        .i_mem_req_accepted (mem_req_accepted),
        .o_mem_req_valid    (mem_req_valid),
        .o_mem_req_addr     (mem_req_addr)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle > cycle_limit) begin
            $display("run exceeded %0d cycles without finishing", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Memory holds the block address in both halves
    function automatic icache_pkg::block_t block_data(input int tag);
        logic [31:0] addr;
        addr = tag << 3;
        return {addr, addr};
    endfunction

    function automatic bit is_pending(input int tag);
        foreach (pend_tag[k]) begin
            if (pend_tag[k] == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Oldest new miss first, else the block after the last accepted one
    task automatic predict_request();
        int tag0;
        int tag1;
        bit have_miss;
        int miss_tag;
        tag0      = read_addr[0].fields.tag;
        tag1      = read_addr[1].fields.tag;
        have_miss = 1'b0;
        miss_tag  = 0;
        if (read_valid[0] && !filled.exists(tag0)) begin
            have_miss = 1'b1;
            miss_tag  = tag0;
        end else if (read_valid[1] && !filled.exists(tag1)) begin
            have_miss = 1'b1;
            miss_tag  = tag1;
        end
        exp_from_miss = have_miss && (!last_miss_valid || miss_tag != last_miss_tag);
        if (exp_from_miss) begin
            exp_req_tag   = miss_tag;
            exp_req_valid = 1'b1;
        end else begin
            exp_req_tag   = (stream_tag + 1) % (1 << icache_pkg::TAG_BITS);
            exp_req_valid = last_miss_valid && (fills < icache_pkg::ICACHE_LINES);
        end
        if (filled.exists(exp_req_tag) || is_pending(exp_req_tag) ||
            pend_tag.size() >= icache_pkg::MSHR_DEPTH) begin
            exp_req_valid = 1'b0;
        end
    endtask

    task automatic check_outputs();
        int          tag;
        bit          exp_hit;
        logic [31:0] exp_addr;
        for (int j = 0; j < 2; j++) begin
            tag     = read_addr[j].fields.tag;
            exp_hit = read_valid[j] && filled.exists(tag);
            if (fills <= icache_pkg::ICACHE_LINES) begin
                assert (read_hit[j] == exp_hit) else
                    stop_on_error($sformatf("mismatch at %0t: o_read_hit[%0d] expected %b got %b",
                                            $time, j, exp_hit, read_hit[j]));
            end
            if (read_hit[j]) begin
                assert (read_data[j] == block_data(tag)) else
                    stop_on_error($sformatf("mismatch at %0t: o_read_data[%0d] expected %h got %h",
                                            $time, j, block_data(tag), read_data[j]));
            end
        end
        if (fills <= icache_pkg::ICACHE_LINES) begin
            predict_request();
            exp_addr = exp_req_tag << icache_pkg::OFFSET_BITS;
            assert (mem_req_valid == exp_req_valid) else
                stop_on_error($sformatf("mismatch at %0t: o_mem_req_valid expected %b got %b",
                                        $time, exp_req_valid, mem_req_valid));
            if (exp_req_valid) begin
                assert (mem_req_addr.raw == exp_addr) else
                    stop_on_error($sformatf("mismatch at %0t: o_mem_req_addr expected %h got %h",
                                            $time, exp_addr, mem_req_addr.raw));
            end
        end else if (mem_req_valid) begin
            tag = mem_req_addr.fields.tag;
            assert (!is_pending(tag)) else
                stop_on_error($sformatf("request for block %h while it is already in flight",
                                        tag));
        end
    endtask

    // Drive one step on the falling edge, then check and do the bookkeeping
    task automatic run_step(input logic [87:0] s);
        @(negedge clock);
        read_valid       = s[81:80];
        read_addr[0]     = s[79:48];
        read_addr[1]     = s[47:16];
        mem_req_accepted = s[8];
        delay            = s[7:0];
        current_req_tag  = icache_pkg::mem_tag_t'(next_tag);
        returning        = (pend_tag.size() > 0) && (pend_due[0] <= cycle);
        mem_data_tag     = '0;
        mem_data         = '0;
        if (returning) begin
            mem_data_tag = icache_pkg::mem_tag_t'(mem_tags[0]);
            mem_data     = block_data(pend_tag[0]);
        end
        #5;
        check_outputs();
        if (returning) begin
            filled[pend_tag.pop_front()] = 1'b1;
            void'(pend_due.pop_front());
            void'(mem_tags.pop_front());
            fills++;
        end
        if (mem_req_valid && mem_req_accepted) begin
            if (exp_from_miss) begin
                last_miss_valid = 1'b1;
                last_miss_tag   = exp_req_tag;
            end
            stream_tag = exp_req_tag;
            pend_tag.push_back(mem_req_addr.fields.tag);
            pend_due.push_back(cycle + delay);
            mem_tags.push_back(next_tag);
            next_tag = (next_tag == 15) ? 1 : next_tag + 1;
        end
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        read_valid       = '0;
        read_addr        = '0;
        current_req_tag  = '0;
        mem_data         = '0;
        mem_data_tag     = '0;
        mem_req_accepted = 1'b0;
        cycle_limit      = 100000;
        fills            = 0;
        next_tag         = 1;
        last_miss_valid  = 1'b0;
        last_miss_tag    = 0;
        stream_tag       = 0;
        exp_req_valid    = 1'b0;
        exp_from_miss    = 1'b0;
        exp_req_tag      = 0;
        $readmemh("testbench/icache_testdata.txt", steps);
        num_steps = 0;
        while (num_steps < 64 && !$isunknown(steps[num_steps])) begin
            num_steps++;
        end
        assert (num_steps > 0) else stop_on_error("no stimulus lines found in the data file");
        cycle_limit = num_steps * 40;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < num_steps; i++) begin
            run_step(steps[i]);
        end
        // Idle until memory has returned everything
        while (pend_tag.size() > 0) begin
            run_step(88'h0);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* sources.f */
hw/icache_pkg.sv
hw/snoop_if.sv
hw/icache_array.sv
hw/miss_status_queue.sv
hw/stream_prefetcher.sv
hw/icache_subsystem.sv
testbench/icache_subsystem_props.sv
testbench/icache_subsystem_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module icache_subsystem_tb
	out=$$(./obj_dir/Vicache_subsystem_tb); echo "$$out"; echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

/* testbench/icache_testdata.txt */
// valid(2 bits) _ addr0 _ addr1 _ accept _ return delay, all hex
// accept held low first, then misses, streaming, hits and a slot 1 miss
03_00000100_00000108_00_00
03_00000100_00000108_00_00
03_00000100_00000108_01_03
03_00000100_00000108_01_02
01_00000100_00000000_01_04
01_00000100_00000000_01_01
03_00000100_00000108_00_00
03_00000104_00000200_01_02
03_00000100_00000200_00_00
03_00000100_00000200_01_03
02_00000000_00000108_01_02
03_00000110_00000204_01_01
00_00000000_00000000_01_02
03_00000300_00000304_01_05
03_00000300_00000308_01_02
01_00000118_00000000_00_00
03_00000200_00000300_01_01
03_00000100_00000108_01_01
